/* include/chain_settings.svh */
/*
 * chain window settings
 * sizes of the instruction window, its entry groups and the execution units
 * that the issue stage feeds
 */

`ifndef CHAIN_SETTINGS_SVH
`define CHAIN_SETTINGS_SVH

// -------------------------------------------------
// window geometry
// -------------------------------------------------
`define CHAIN_GROUP_NUM 2
`define CHAIN_DEPTH     3
`define CHAIN_SLOTS     (`CHAIN_GROUP_NUM * `CHAIN_DEPTH)

// -------------------------------------------------
// execution units
// -------------------------------------------------
`define CHAIN_OP_NUM    2
// alu lanes first, mul/div takes the last index
`define CHAIN_FUNC_NUM  (`CHAIN_OP_NUM + 1)
`define CHAIN_XLEN      32
`define CHAIN_PARA_LEN  8

`endif

/* logic/chain_pkg.sv */
/*
 * chain package
 * shared types of the instruction window manager
 */

`include "chain_settings.svh"

package chain_pkg;

	// -------------------------------------------------
	// vectors over the window
	// -------------------------------------------------

	// bit index equals slot index, slot 0 is the newest
	typedef logic [`CHAIN_SLOTS-1:0] slot_vec_t;

	// one bit per slot of a single group
	typedef logic [`CHAIN_GROUP_NUM-1:0] group_vec_t;

	// row i bit j set means slot i reads the result of slot j
	typedef slot_vec_t [`CHAIN_SLOTS-1:0] dep_map_t;

	// one bit per execution unit
	typedef logic [`CHAIN_FUNC_NUM-1:0] func_vec_t;

	// -------------------------------------------------
	// payload words
	// -------------------------------------------------
	typedef logic [`CHAIN_XLEN-1:0] xlen_t;
	typedef logic [`CHAIN_PARA_LEN-1:0] para_t;

	typedef enum logic {
		unit_alu,
		unit_muldiv
	} unit_kind_e;

	// one decoded instruction entering the window
	// dep vectors already address the window after the shift
	typedef struct packed {
		logic       valid;
		unit_kind_e kind;
		slot_vec_t  rs0_dep;
		slot_vec_t  rs1_dep;
	} slot_in_t;

	// request towards one execution unit
	typedef struct packed {
		logic  valid;
		para_t para;
	} func_req_t;

endpackage

/* logic/chain_window.sv */
/*
 * chain window
 * per-slot state registers and dependency maps, decides when the oldest
 * group may leave and shifts the whole window by one group
 */

`include "chain_settings.svh"

module chain_window (
	input  logic                                       clk,
	input  logic                                       reset,
	input  chain_pkg::slot_in_t [`CHAIN_GROUP_NUM-1:0] in_group,
	input  chain_pkg::slot_vec_t [`CHAIN_FUNC_NUM-1:0] issued,
	input  chain_pkg::slot_vec_t                       rd_set,
	output logic                                       chain_step,
	output chain_pkg::slot_vec_t                       slot_valid,
	output chain_pkg::slot_vec_t                       slot_alu,
	output chain_pkg::slot_vec_t                       slot_muldiv,
	output chain_pkg::slot_vec_t                       pending,
	output chain_pkg::slot_vec_t                       rd_valid,
	output chain_pkg::dep_map_t                        rs0_map,
	output chain_pkg::dep_map_t                        rs1_map
);
	import chain_pkg::*;

	// first slot of the oldest group
	localparam int OLDEST = `CHAIN_SLOTS - `CHAIN_GROUP_NUM;

	slot_vec_t  issued_any;
	slot_vec_t  keep_pending;
	slot_vec_t  keep_rd_valid;
	group_vec_t enter_valid;
	group_vec_t enter_alu;
	group_vec_t enter_muldiv;
	group_vec_t oldest_done;
	dep_map_t   step_rs0_map;
	dep_map_t   step_rs1_map;

	// -------------------------------------------------
	// state kept without a step
	// -------------------------------------------------
	always_comb begin
		issued_any = '0;
		for (int u = 0; u < `CHAIN_FUNC_NUM; u++) begin
			issued_any = issued_any | issued[u];
		end
	end

	assign keep_pending  = pending & ~issued_any;
	assign keep_rd_valid = rd_valid | rd_set;

	// -------------------------------------------------
	// step decision from the oldest group
	// -------------------------------------------------
	always_comb begin
		for (int g = 0; g < `CHAIN_GROUP_NUM; g++) begin
			oldest_done[g] = ~slot_valid[OLDEST+g] |
				(~pending[OLDEST+g] & rd_valid[OLDEST+g]);
		end
	end

	assign chain_step = &oldest_done;

	// -------------------------------------------------
	// entering group and shifted maps
	// -------------------------------------------------
	always_comb begin
		for (int g = 0; g < `CHAIN_GROUP_NUM; g++) begin
			enter_valid[g]  = in_group[g].valid;
			enter_alu[g]    = in_group[g].valid && in_group[g].kind == unit_alu;
			enter_muldiv[g] = in_group[g].valid && in_group[g].kind == unit_muldiv;
		end
	end

	// rows move up one group and so do the columns inside each row
	always_comb begin
		for (int i = 0; i < `CHAIN_GROUP_NUM; i++) begin
			step_rs0_map[i] = in_group[i].valid ? in_group[i].rs0_dep : '0;
			step_rs1_map[i] = in_group[i].valid ? in_group[i].rs1_dep : '0;
		end
		for (int i = `CHAIN_GROUP_NUM; i < `CHAIN_SLOTS; i++) begin
			step_rs0_map[i] = rs0_map[i-`CHAIN_GROUP_NUM] << `CHAIN_GROUP_NUM;
			step_rs1_map[i] = rs1_map[i-`CHAIN_GROUP_NUM] << `CHAIN_GROUP_NUM;
		end
	end

	// -------------------------------------------------
	// slot registers
	// -------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			slot_valid  <= '0;
			slot_alu    <= '0;
			slot_muldiv <= '0;
			pending     <= '0;
			rd_valid    <= '0;
			rs0_map     <= '0;
			rs1_map     <= '0;
		end else if (chain_step) begin
			slot_valid  <= (slot_valid << `CHAIN_GROUP_NUM) | slot_vec_t'(enter_valid);
			slot_alu    <= (slot_alu << `CHAIN_GROUP_NUM) | slot_vec_t'(enter_alu);
			slot_muldiv <= (slot_muldiv << `CHAIN_GROUP_NUM) | slot_vec_t'(enter_muldiv);
			pending     <= (keep_pending << `CHAIN_GROUP_NUM) | slot_vec_t'(enter_valid);
			// new entries start without a result
			rd_valid    <= keep_rd_valid << `CHAIN_GROUP_NUM;
			rs0_map     <= step_rs0_map;
			rs1_map     <= step_rs1_map;
		end else begin
			pending  <= keep_pending;
			rd_valid <= keep_rd_valid;
		end
	end

	// -------------------------------------------------
	// checks
	// -------------------------------------------------
	// results routed back by the switches land on live slots only
	a_rd_set_live: assert property (@(posedge clk) disable iff (reset)
		(rd_set & ~slot_valid) == '0);

endmodule

/* logic/chain_issue.sv */
/*
 * chain issue
 * finds ready slots, grants them oldest first to the alu lanes and the
 * mul/div unit, and drives the unit requests from the approved grants
 */

`include "chain_settings.svh"

module chain_issue (
	input  logic                                       clk,
	input  logic                                       reset,
	input  logic                                       chain_step,
	input  chain_pkg::slot_vec_t                       slot_valid,
	input  chain_pkg::slot_vec_t                       slot_alu,
	input  chain_pkg::slot_vec_t                       slot_muldiv,
	input  chain_pkg::slot_vec_t                       pending,
	input  chain_pkg::slot_vec_t                       rd_valid,
	input  chain_pkg::dep_map_t                        rs0_map,
	input  chain_pkg::dep_map_t                        rs1_map,
	input  chain_pkg::para_t    [`CHAIN_SLOTS-1:0]     slot_para,
	input  chain_pkg::func_vec_t                       func_ack_busy,
	output chain_pkg::func_req_t [`CHAIN_FUNC_NUM-1:0] func_req,
	output chain_pkg::slot_vec_t [`CHAIN_FUNC_NUM-1:0] issued
);
	import chain_pkg::*;

	localparam int MULDIV = `CHAIN_FUNC_NUM - 1;

	slot_vec_t                       issued_any;
	slot_vec_t                       rs_ready;
	slot_vec_t                       candidate;
	slot_vec_t                       alu_left;
	slot_vec_t [`CHAIN_FUNC_NUM-1:0] grant;
	slot_vec_t [`CHAIN_FUNC_NUM-1:0] approved;

	// keeps only the highest set bit which is the oldest slot
	function automatic slot_vec_t pick_oldest(input slot_vec_t cand);
		slot_vec_t sel;
		logic      found;
		int        s;
		sel   = '0;
		found = 1'b0;
		for (s = `CHAIN_SLOTS - 1; s >= 0; s--) begin
			if (cand[s] && !found) begin
				sel[s] = 1'b1;
				found  = 1'b1;
			end
		end
		return sel;
	endfunction

	// -------------------------------------------------
	// issue towards the units
	// -------------------------------------------------
	always_comb begin
		issued_any = '0;
		for (int u = 0; u < `CHAIN_FUNC_NUM; u++) begin
			// a busy unit drops the request and the slot stays pending
			issued[u]  = approved[u] & {`CHAIN_SLOTS{~func_ack_busy[u]}};
			issued_any = issued_any | issued[u];
		end
	end

	always_comb begin
		for (int u = 0; u < `CHAIN_FUNC_NUM; u++) begin
			func_req[u].valid = |issued[u];
			func_req[u].para  = '0;
			for (int s = 0; s < `CHAIN_SLOTS; s++) begin
				if (issued[u][s]) begin
					func_req[u].para = func_req[u].para | slot_para[s];
				end
			end
		end
	end

	// -------------------------------------------------
	// readiness and selection
	// -------------------------------------------------
	always_comb begin
		for (int s = 0; s < `CHAIN_SLOTS; s++) begin
			rs_ready[s] = ~|(rs0_map[s] & ~rd_valid) & ~|(rs1_map[s] & ~rd_valid);
		end
	end

	// slots going out this cycle are masked so they are not granted again
	assign candidate = slot_valid & pending & ~issued_any & rs_ready;

	always_comb begin
		alu_left = candidate & slot_alu;
		for (int l = 0; l < `CHAIN_OP_NUM; l++) begin
			grant[l] = pick_oldest(alu_left);
			alu_left = alu_left & ~grant[l];
		end
		grant[MULDIV] = pick_oldest(candidate & slot_muldiv);
	end

	// grants follow the window when it steps
	always_ff @(posedge clk) begin
		if (reset) begin
			approved <= '0;
		end else begin
			for (int u = 0; u < `CHAIN_FUNC_NUM; u++) begin
				approved[u] <= chain_step ? (grant[u] << `CHAIN_GROUP_NUM) : grant[u];
			end
		end
	end

	// -------------------------------------------------
	// checks
	// -------------------------------------------------
	for (genvar u = 0; u < `CHAIN_FUNC_NUM; u++) begin : g_approved_check
		// an approved slot is still live and waiting for issue
		a_approved_pending: assert property (@(posedge clk) disable iff (reset)
			(approved[u] & ~(slot_valid & pending)) == '0);
	end

endmodule

/* logic/chain_result.sv */
/*
 * chain result
 * remembers which slot each unit works for and turns unit acknowledges
 * into per-slot result valid and data
 */

`include "chain_settings.svh"

module chain_result (
	input  logic                                       clk,
	input  logic                                       reset,
	input  logic                                       chain_step,
	input  chain_pkg::slot_vec_t [`CHAIN_FUNC_NUM-1:0] issued,
	input  chain_pkg::func_vec_t                       func_ack_valid,
	input  chain_pkg::func_vec_t                       func_ack_busy,
	input  chain_pkg::xlen_t    [`CHAIN_FUNC_NUM-1:0]  func_ack_data,
	output chain_pkg::slot_vec_t                       rd_set,
	output chain_pkg::slot_vec_t                       chain_rd_feed_valid,
	output chain_pkg::xlen_t    [`CHAIN_SLOTS-1:0]     chain_rd_feed_data
);
	import chain_pkg::*;

	slot_vec_t [`CHAIN_FUNC_NUM-1:0] unit_switch;
	slot_vec_t [`CHAIN_FUNC_NUM-1:0] switch_next;

	// -------------------------------------------------
	// unit to slot switches
	// -------------------------------------------------
	always_comb begin
		for (int u = 0; u < `CHAIN_FUNC_NUM; u++) begin
			// busy holds the slot of the running operation
			switch_next[u] = issued[u] | (func_ack_busy[u] ? unit_switch[u] : '0);
			if (chain_step) begin
				switch_next[u] = switch_next[u] << `CHAIN_GROUP_NUM;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			unit_switch <= '0;
		end else begin
			unit_switch <= switch_next;
		end
	end

	// -------------------------------------------------
	// acknowledge routing
	// -------------------------------------------------
	always_comb begin
		rd_set = '0;
		for (int s = 0; s < `CHAIN_SLOTS; s++) begin
			chain_rd_feed_data[s] = '0;
		end
		for (int u = 0; u < `CHAIN_FUNC_NUM; u++) begin
			if (func_ack_valid[u]) begin
				rd_set = rd_set | unit_switch[u];
			end
			for (int s = 0; s < `CHAIN_SLOTS; s++) begin
				if (func_ack_valid[u] && unit_switch[u][s]) begin
					chain_rd_feed_data[s] = chain_rd_feed_data[s] | func_ack_data[u];
				end
			end
		end
	end

	assign chain_rd_feed_valid = rd_set;

	// -------------------------------------------------
	// checks
	// -------------------------------------------------
	for (genvar u = 0; u < `CHAIN_FUNC_NUM; u++) begin : g_ack_check
		// an ack always belongs to a request the manager sent earlier
		a_ack_has_slot: assert property (@(posedge clk) disable iff (reset)
			func_ack_valid[u] |-> unit_switch[u] != '0);
	end

endmodule

/* logic/chain_manager.sv */
/*
 * chain manager
 * instruction window of the out-of-order issue stage, tracks slot state,
 * issues ready work to the alu lanes and the mul/div unit, routes results back
 */

`include "chain_settings.svh"

module chain_manager (
	input  logic                                       clk,
	input  logic                                       reset,
	input  chain_pkg::slot_in_t [`CHAIN_GROUP_NUM-1:0] in_group,
	input  chain_pkg::para_t    [`CHAIN_SLOTS-1:0]     slot_para,
	output chain_pkg::func_req_t [`CHAIN_FUNC_NUM-1:0] func_req,
	input  chain_pkg::func_vec_t                       func_ack_valid,
	input  chain_pkg::func_vec_t                       func_ack_busy,
	input  chain_pkg::xlen_t    [`CHAIN_FUNC_NUM-1:0]  func_ack_data,
	output logic                                       chain_step,
	output chain_pkg::slot_vec_t                       chain_rd_feed_valid,
	output chain_pkg::xlen_t    [`CHAIN_SLOTS-1:0]     chain_rd_feed_data
);
	import chain_pkg::*;

	slot_vec_t                        slot_valid;
	slot_vec_t                        slot_alu;
	slot_vec_t                        slot_muldiv;
	slot_vec_t                        pending;
	slot_vec_t                        rd_valid;
	dep_map_t                         rs0_map;
	dep_map_t                         rs1_map;
	slot_vec_t [`CHAIN_FUNC_NUM-1:0]  issued;
	slot_vec_t                        rd_set;

	chain_window chain_window_inst (
		.clk         (clk),
		.reset       (reset),
		.in_group    (in_group),
		.issued      (issued),
		.rd_set      (rd_set),
		.chain_step  (chain_step),
		.slot_valid  (slot_valid),
		.slot_alu    (slot_alu),
		.slot_muldiv (slot_muldiv),
		.pending     (pending),
		.rd_valid    (rd_valid),
		.rs0_map     (rs0_map),
		.rs1_map     (rs1_map)
	);

	chain_issue chain_issue_inst (
		.clk           (clk),
		.reset         (reset),
		.chain_step    (chain_step),
		.slot_valid    (slot_valid),
		.slot_alu      (slot_alu),
		.slot_muldiv   (slot_muldiv),
		.pending       (pending),
		.rd_valid      (rd_valid),
		.rs0_map       (rs0_map),
		.rs1_map       (rs1_map),
		.slot_para     (slot_para),
		.func_ack_busy (func_ack_busy),
		.func_req      (func_req),
		.issued        (issued)
	);

	chain_result chain_result_inst (
		.clk                 (clk),
		.reset               (reset),
		.chain_step          (chain_step),
		.issued              (issued),
		.func_ack_valid      (func_ack_valid),
		.func_ack_busy       (func_ack_busy),
		.func_ack_data       (func_ack_data),
		.rd_set              (rd_set),
		.chain_rd_feed_valid (chain_rd_feed_valid),
		.chain_rd_feed_data  (chain_rd_feed_data)
	);

endmodule

/* dv/chain_clock_gen.sv */
/*
 * chain clock generator
 * free running testbench clock with a synchronous reset held for the
 * first cycles of the run
 */

module chain_clock_gen (
	output logic clk,
	output logic reset
);
	localparam int HALF_PERIOD  = 50;
	localparam int RESET_CYCLES = 16;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

/* dv/chain_manager_tb.sv */
/*
 * chain manager testbench
 * feeds instruction groups from a table, models the execution units
 * and checks issue order, dependencies, steps and result routing
 */

`include "chain_settings.svh"

module chain_manager_tb;
	import chain_pkg::*;

	localparam int ROWS        = 8;
	localparam int OLDEST      = `CHAIN_SLOTS - `CHAIN_GROUP_NUM;
	localparam int MULDIV      = `CHAIN_FUNC_NUM - 1;
	localparam int RESET_LIMIT = 40;
	localparam int ROW_LIMIT   = 200;
	localparam int DRAIN_LIMIT = 400;

	logic                                 clk;
	logic                                 reset;
	slot_in_t  [`CHAIN_GROUP_NUM-1:0]     in_group;
	para_t     [`CHAIN_SLOTS-1:0]         slot_para;
	func_req_t [`CHAIN_FUNC_NUM-1:0]      func_req;
	func_vec_t                            func_ack_valid;
	func_vec_t                            func_ack_busy;
	xlen_t     [`CHAIN_FUNC_NUM-1:0]      func_ack_data;
	logic                                 chain_step;
	slot_vec_t                            chain_rd_feed_valid;
	xlen_t     [`CHAIN_SLOTS-1:0]         chain_rd_feed_data;

	// -------------------------------------------------
	// stimulus table with one group per row
	// -------------------------------------------------
	para_t      row_para [ROWS][`CHAIN_GROUP_NUM];
	unit_kind_e row_kind [ROWS][`CHAIN_GROUP_NUM];
	slot_vec_t  row_rs0  [ROWS][`CHAIN_GROUP_NUM];
	slot_vec_t  row_rs1  [ROWS][`CHAIN_GROUP_NUM];

	// window model indexed like the DUT slots
	logic      win_valid [`CHAIN_SLOTS];
	para_t     [`CHAIN_SLOTS-1:0] win_para;

	// per instruction bookkeeping indexed by para
	int        req_count [256];
	logic      acked     [256];
	logic      muldiv_of [256];
	logic      dep0_has  [256];
	logic      dep1_has  [256];
	para_t     dep0_para [256];
	para_t     dep1_para [256];

	// unit models
	para_t     unit_para [`CHAIN_FUNC_NUM];
	int        unit_cnt  [`CHAIN_FUNC_NUM];
	func_vec_t nxt_ack;
	func_vec_t nxt_busy;
	xlen_t     [`CHAIN_FUNC_NUM-1:0] nxt_data;
	logic      rng_seeded = 1'b0;

	int        cur_row;
	int        rows_taken;
	int        ack_total;
	int        mismatches;

	chain_clock_gen chain_clock_gen_inst (
		.clk   (clk),
		.reset (reset)
	);

	chain_manager chain_manager_inst (
		.clk                 (clk),
		.reset               (reset),
		.in_group            (in_group),
		.slot_para           (slot_para),
		.func_req            (func_req),
		.func_ack_valid      (func_ack_valid),
		.func_ack_busy       (func_ack_busy),
		.func_ack_data       (func_ack_data),
		.chain_step          (chain_step),
		.chain_rd_feed_valid (chain_rd_feed_valid),
		.chain_rd_feed_data  (chain_rd_feed_data)
	);

	// -------------------------------------------------
	// compare tasks
	// -------------------------------------------------
	task automatic check_req(input para_t got, input para_t exp, input string what);
		if (got !== exp) begin
			mismatches++;
			$display("error at %0t: %s, got %0h expected %0h", $time, what, got, exp);
			$display("** FAIL **");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic check_feed(input xlen_t got, input xlen_t exp, input string what);
		if (got !== exp) begin
			mismatches++;
			$display("error at %0t: %s, got %0h expected %0h", $time, what, got, exp);
			$display("** FAIL **");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic check_step(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			mismatches++;
			$display("error at %0t: %s, got %b expected %b", $time, what, got, exp);
			$display("** FAIL **");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("** FAIL **");
		$fatal(1, "run aborted");
	endtask

	task automatic set_slot(input int r, input int g, input para_t p, input unit_kind_e k,
			input slot_vec_t rs0, input slot_vec_t rs1);
		row_para[r][g] = p;
		row_kind[r][g] = k;
		row_rs0[r][g]  = rs0;
		row_rs1[r][g]  = rs1;
	endtask

	// dep bits address the window after the shift
	// slot 1 is older than slot 0
	task automatic load_table();
		set_slot(0, 1, 8'h11, unit_alu,    6'b000000, 6'b000000);
		set_slot(0, 0, 8'h10, unit_alu,    6'b000010, 6'b000000);
		set_slot(1, 1, 8'h21, unit_muldiv, 6'b000100, 6'b000000);
		set_slot(1, 0, 8'h20, unit_alu,    6'b001000, 6'b000100);
		set_slot(2, 1, 8'h31, unit_muldiv, 6'b001000, 6'b000000);
		set_slot(2, 0, 8'h30, unit_muldiv, 6'b000000, 6'b000000);
		set_slot(3, 1, 8'h41, unit_alu,    6'b000000, 6'b000000);
		set_slot(3, 0, 8'h40, unit_alu,    6'b000000, 6'b000000);
		set_slot(4, 1, 8'h51, unit_alu,    6'b010000, 6'b000000);
		set_slot(4, 0, 8'h50, unit_muldiv, 6'b000000, 6'b000010);
		set_slot(5, 1, 8'h61, unit_alu,    6'b000000, 6'b000000);
		set_slot(5, 0, 8'h60, unit_alu,    6'b000100, 6'b001000);
		set_slot(6, 1, 8'h71, unit_muldiv, 6'b000000, 6'b000000);
		set_slot(6, 0, 8'h70, unit_alu,    6'b000000, 6'b000000);
		set_slot(7, 1, 8'h81, unit_alu,    6'b100000, 6'b000000);
		set_slot(7, 0, 8'h80, unit_alu,    6'b000000, 6'b000010);
	endtask

	function automatic int slot_of(input para_t p);
		int found;
		found = -1;
		for (int s = 0; s < `CHAIN_SLOTS; s++) begin
			if (win_valid[s] && win_para[s] == p) begin
				found = s;
			end
		end
		return found;
	endfunction

	function automatic int lowest_bit(input slot_vec_t v);
		int found;
		found = -1;
		for (int s = `CHAIN_SLOTS - 1; s >= 0; s--) begin
			if (v[s]) begin
				found = s;
			end
		end
		return found;
	endfunction

	// -------------------------------------------------
	// unit and window models sampled on the falling edge
	// -------------------------------------------------
	always @(negedge clk) begin : monitor
		int        s;
		int        b;
		int        n_ack;
		int        lane_slot [2];
		logic      exp_step;
		para_t     p;
		logic [31:0] rnd;
		if (!rng_seeded) begin
			void'($urandom(90314));
			rng_seeded = 1'b1;
		end
		if (reset !== 1'b0) begin
			for (int i = 0; i < 256; i++) begin
				req_count[i] = 0;
				acked[i]     = 1'b0;
			end
			for (s = 0; s < `CHAIN_SLOTS; s++) begin
				win_valid[s] = 1'b0;
				win_para[s]  = '0;
			end
			for (int u = 0; u < `CHAIN_FUNC_NUM; u++) begin
				unit_cnt[u] = 0;
			end
			nxt_ack  = '0;
			nxt_busy = '0;
			nxt_data = '0;
		end else begin
			// step only when the oldest group holds nothing unacknowledged
			exp_step = 1'b1;
			for (s = OLDEST; s < `CHAIN_SLOTS; s++) begin
				if (win_valid[s] && !acked[win_para[s]]) begin
					exp_step = 1'b0;
				end
			end
			check_step(chain_step, exp_step, "chain_step against oldest group");

			for (int u = 0; u < `CHAIN_FUNC_NUM; u++) begin
				if (func_req[u].valid) begin
					p = func_req[u].para;
					if (slot_of(p) < 0) begin
						stop_run("a request carries a para that is not in the window");
					end
					check_req(para_t'(req_count[p]), para_t'(0), "earlier requests of para");
					check_step(muldiv_of[p], u == MULDIV, "unit kind of request");
					if (dep0_has[p]) begin
						check_step(acked[dep0_para[p]], 1'b1, "rs0 producer acked first");
					end
					if (dep1_has[p]) begin
						check_step(acked[dep1_para[p]], 1'b1, "rs1 producer acked first");
					end
					req_count[p]++;
				end
			end
			if (func_req[0].valid && func_req[1].valid) begin
				lane_slot[0] = slot_of(func_req[0].para);
				lane_slot[1] = slot_of(func_req[1].para);
				check_step(lane_slot[0] > lane_slot[1], 1'b1, "lane 0 takes the older slot");
			end

			n_ack = 0;
			for (int u = 0; u < `CHAIN_FUNC_NUM; u++) begin
				if (func_ack_valid[u]) begin
					s = slot_of(unit_para[u]);
					if (s < 0) begin
						stop_run("an ack belongs to an instruction that left the window");
					end
					check_step(chain_rd_feed_valid[s], 1'b1, "feed valid of acked slot");
					check_feed(chain_rd_feed_data[s], func_ack_data[u], "feed data of acked slot");
					acked[unit_para[u]] = 1'b1;
					ack_total++;
					n_ack++;
				end
			end
			check_feed(xlen_t'($countones(chain_rd_feed_valid)), xlen_t'(n_ack),
				"number of feed valid slots");

			// a unit that acks this cycle is free to take a new request
			for (int u = 0; u < `CHAIN_FUNC_NUM; u++) begin
				if (func_req[u].valid) begin
					unit_para[u] = func_req[u].para;
					unit_cnt[u]  = 1 + ($urandom % 4);
				end
				nxt_ack[u]  = 1'b0;
				nxt_busy[u] = 1'b0;
				nxt_data[u] = '0;
				if (unit_cnt[u] == 1) begin
					rnd         = $urandom;
					nxt_ack[u]  = 1'b1;
					nxt_data[u] = {unit_para[u], rnd[23:0]};
					unit_cnt[u] = 0;
				end else if (unit_cnt[u] > 1) begin
					nxt_busy[u] = 1'b1;
					unit_cnt[u]--;
				end
			end

			if (chain_step) begin
				for (s = `CHAIN_SLOTS - 1; s >= `CHAIN_GROUP_NUM; s--) begin
					win_valid[s] = win_valid[s-`CHAIN_GROUP_NUM];
					win_para[s]  = win_para[s-`CHAIN_GROUP_NUM];
				end
				for (int g = 0; g < `CHAIN_GROUP_NUM; g++) begin
					win_valid[g] = in_group[g].valid;
					win_para[g]  = (cur_row >= 0) ? row_para[cur_row][g] : '0;
				end
				if (cur_row >= 0) begin
					for (int g = 0; g < `CHAIN_GROUP_NUM; g++) begin
						p            = row_para[cur_row][g];
						muldiv_of[p] = row_kind[cur_row][g] == unit_muldiv;
						b            = lowest_bit(row_rs0[cur_row][g]);
						dep0_has[p]  = b >= 0;
						dep0_para[p] = (b >= 0) ? win_para[b] : '0;
						b            = lowest_bit(row_rs1[cur_row][g]);
						dep1_has[p]  = b >= 0;
						dep1_para[p] = (b >= 0) ? win_para[b] : '0;
					end
					rows_taken++;
				end
			end
		end
	end

	always @(posedge clk) begin
		func_ack_valid <= nxt_ack;
		func_ack_busy  <= nxt_busy;
		func_ack_data  <= nxt_data;
		slot_para      <= win_para;
	end

	// -------------------------------------------------
	// main sequence
	// -------------------------------------------------
	initial begin
		int waited;
		in_group       = '0;
		slot_para      = '0;
		func_ack_valid = '0;
		func_ack_busy  = '0;
		func_ack_data  = '0;
		nxt_ack        = '0;
		nxt_busy       = '0;
		nxt_data       = '0;
		cur_row        = -1;
		rows_taken     = 0;
		ack_total      = 0;
		mismatches     = 0;
		load_table();

		waited = 0;
		while (reset !== 1'b0) begin
			@(posedge clk);
			waited++;
			if (waited > RESET_LIMIT) begin
				stop_run("reset was never released");
			end
		end
		@(negedge clk);
		for (int u = 0; u < `CHAIN_FUNC_NUM; u++) begin
			check_step(func_req[u].valid, 1'b0, "request valid after reset");
		end
		check_feed(xlen_t'(chain_rd_feed_valid), '0, "feed valid after reset");
		check_step(chain_step, 1'b1, "chain_step after reset");

		@(posedge clk);
		for (int r = 0; r < ROWS; r++) begin
			for (int g = 0; g < `CHAIN_GROUP_NUM; g++) begin
				in_group[g].valid   <= 1'b1;
				in_group[g].kind    <= row_kind[r][g];
				in_group[g].rs0_dep <= row_rs0[r][g];
				in_group[g].rs1_dep <= row_rs1[r][g];
			end
			cur_row = r;
			waited  = 0;
			do begin
				@(posedge clk);
				waited++;
				if (waited > ROW_LIMIT) begin
					stop_run("a table row was never taken by a window step");
				end
			end while (rows_taken <= r);
		end
		in_group <= '0;
		cur_row = -1;

		waited = 0;
		while (ack_total < ROWS * `CHAIN_GROUP_NUM) begin
			@(posedge clk);
			waited++;
			if (waited > DRAIN_LIMIT) begin
				stop_run("not every instruction was acknowledged");
			end
		end

		for (int r = 0; r < ROWS; r++) begin
			for (int g = 0; g < `CHAIN_GROUP_NUM; g++) begin
				check_req(para_t'(req_count[row_para[r][g]]), para_t'(1), "requests per para");
			end
		end

		if (mismatches == 0) begin
			$display("** PASS **");
			$finish;
		end else begin
			$display("** FAIL **");
			$fatal(1, "mismatches were counted");
		end
	end

endmodule

/* src.f */
+incdir+include
logic/chain_pkg.sv
logic/chain_window.sv
logic/chain_issue.sv
logic/chain_result.sv
logic/chain_manager.sv
dv/chain_clock_gen.sv
dv/chain_manager_tb.sv

/* Bender.yml */
package:
  name: chain_manager

export_include_dirs:
  - include

sources:
  - files:
      - logic/chain_pkg.sv
      - logic/chain_window.sv
      - logic/chain_issue.sv
      - logic/chain_result.sv
      - logic/chain_manager.sv
  - target: test
    files:
      - dv/chain_clock_gen.sv
      - dv/chain_manager_tb.sv
